// ==== design/exe_pkg.sv ====
package exe_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [3:0]  strb_t;
    typedef logic [1:0]  req_size_t;

    // one-hot alu operation, indexed by the bit positions below
    localparam int ALU_OP_W = 12;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [3:0] mem_op_t;

    localparam mem_op_t MEM_NONE = 4'd0;
    localparam mem_op_t MEM_LB   = 4'd1;
    localparam mem_op_t MEM_LBU  = 4'd2;
    localparam mem_op_t MEM_LH   = 4'd3;
    localparam mem_op_t MEM_LHU  = 4'd4;
    localparam mem_op_t MEM_LW   = 4'd5;
    localparam mem_op_t MEM_SB   = 4'd6;
    localparam mem_op_t MEM_SH   = 4'd7;
    localparam mem_op_t MEM_SW   = 4'd8;

    typedef logic [1:0] ovf_kind_t;

    localparam ovf_kind_t OVF_NONE = 2'd0;
    localparam ovf_kind_t OVF_ADD  = 2'd1;
    localparam ovf_kind_t OVF_SUB  = 2'd2;

    typedef logic [4:0] ex_code_t;

    localparam ex_code_t EX_NONE = 5'd31;
    localparam ex_code_t EX_ADEL = 5'd4;
    localparam ex_code_t EX_ADES = 5'd5;
    localparam ex_code_t EX_OV   = 5'd12;

    // the data bus always asks for a full word
    localparam req_size_t SIZE_WORD = 2'd2;

    typedef struct packed {
        ex_code_t  ex_code;
        alu_op_t   alu_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_uimm;
        logic      src2_is_8;
        ovf_kind_t ovf;
        mem_op_t   mem_op;
        logic      gr_we;
        reg_idx_t  dest;
        imm_t      imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
    } ds_to_es_t;

    typedef struct packed {
        ex_code_t ex_code;
        word_t    bad_vaddr;
        logic     res_from_mem;
        logic     gr_we;
        reg_idx_t dest;
        word_t    result;
        word_t    pc;
    } es_to_ms_t;

    typedef struct packed {
        reg_idx_t dest;
        logic     load_op;
        word_t    data;
    } es_fwd_t;

    typedef struct packed {
        logic      en;
        logic      wr;
        req_size_t size;
        strb_t     wstrb;
        word_t     addr;
        word_t     wdata;
    } data_req_t;

    function automatic logic is_load_op(mem_op_t op);
        return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    endfunction

    function automatic logic is_store_op(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

endpackage

// ==== design/exe_alu.sv ====
module exe_alu
    import exe_pkg::*;
(
    input  ds_to_es_t instr,
    output word_t     result,
    output logic      overflow
);

    word_t src1;
    word_t src2;
    word_t add_res;
    word_t sub_res;
    word_t slt_res;
    word_t sltu_res;
    word_t and_res;
    word_t nor_res;
    word_t or_res;
    word_t xor_res;
    word_t sll_res;
    word_t srl_res;
    word_t sra_res;
    word_t lui_res;
    logic  add_ovf;
    logic  sub_ovf;

    // operand 1: shift amount, pc or rs
    always_comb begin
        if (instr.src1_is_sa) begin
            src1 = {27'b0, instr.imm[10:6]};
        end else if (instr.src1_is_pc) begin
            src1 = instr.pc;
        end else begin
            src1 = instr.rs_value;
        end
    end

    // operand 2: immediates, link offset or rt
    always_comb begin
        if (instr.src2_is_uimm) begin
            src2 = {16'b0, instr.imm};
        end else if (instr.src2_is_imm) begin
            src2 = {{16{instr.imm[15]}}, instr.imm};
        end else if (instr.src2_is_8) begin
            src2 = 32'd8;
        end else begin
            src2 = instr.rt_value;
        end
    end

    assign add_res  = src1 + src2;
    assign sub_res  = src1 - src2;
    assign slt_res  = {31'b0, $signed(src1) < $signed(src2)};
    assign sltu_res = {31'b0, src1 < src2};
    assign and_res  = src1 & src2;
    assign nor_res  = ~(src1 | src2);
    assign or_res   = src1 | src2;
    assign xor_res  = src1 ^ src2;

    // shifts move src2 by the low five bits of src1
    assign sll_res = src2 << src1[4:0];
    assign srl_res = src2 >> src1[4:0];
    assign sra_res = word_t'($signed(src2) >>> src1[4:0]);
    assign lui_res = {src2[15:0], 16'b0};

    // one-hot select
    assign result = ({32{instr.alu_op[ALU_ADD]}}  & add_res)
                  | ({32{instr.alu_op[ALU_SUB]}}  & sub_res)
                  | ({32{instr.alu_op[ALU_SLT]}}  & slt_res)
                  | ({32{instr.alu_op[ALU_SLTU]}} & sltu_res)
                  | ({32{instr.alu_op[ALU_AND]}}  & and_res)
                  | ({32{instr.alu_op[ALU_NOR]}}  & nor_res)
                  | ({32{instr.alu_op[ALU_OR]}}   & or_res)
                  | ({32{instr.alu_op[ALU_XOR]}}  & xor_res)
                  | ({32{instr.alu_op[ALU_SLL]}}  & sll_res)
                  | ({32{instr.alu_op[ALU_SRL]}}  & srl_res)
                  | ({32{instr.alu_op[ALU_SRA]}}  & sra_res)
                  | ({32{instr.alu_op[ALU_LUI]}}  & lui_res);

    // signed overflow
    assign add_ovf = (src1[31] == src2[31]) && (add_res[31] != src1[31]);
    assign sub_ovf = (src1[31] != src2[31]) && (sub_res[31] != src1[31]);

    always_comb begin
        case (instr.ovf)
            OVF_ADD: overflow = add_ovf;
            OVF_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

// ==== design/exe_mem_access.sv ====
module exe_mem_access
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      valid,
    input  logic      leave,
    input  mem_op_t   mem_op,
    input  logic      early_ex,
    input  word_t     addr,
    input  word_t     rt_value,
    input  logic      data_addr_ok,
    output data_req_t data_req,
    output logic      adel,
    output logic      ades,
    output logic      mem_ready
);

    typedef enum logic {
        req_idle,
        req_sent
    } req_state_t;

    req_state_t state;
    req_state_t state_next;
    logic       load_op;
    logic       store_op;
    logic       has_access;
    logic       word_access;
    logic       half_access;
    logic       misaligned;
    logic       req_needed;
    logic       accept;
    strb_t      lane_strb;
    word_t      store_data;

    assign load_op    = is_load_op(mem_op);
    assign store_op   = is_store_op(mem_op);
    assign has_access = load_op || store_op;

    assign word_access = (mem_op == MEM_LW) || (mem_op == MEM_SW);
    assign half_access = (mem_op == MEM_LH) || (mem_op == MEM_LHU) || (mem_op == MEM_SH);

    // alignment checks
    assign misaligned = (word_access && (addr[1:0] != 2'b00))
                      || (half_access && addr[0]);

    assign adel = load_op && misaligned;
    assign ades = store_op && misaligned;

    // replicate store data into every lane it may land in
    always_comb begin
        lane_strb  = '0;
        store_data = rt_value;
        case (mem_op)
            MEM_SB: begin
                store_data = {4{rt_value[7:0]}};
                lane_strb  = strb_t'(4'b0001 << addr[1:0]);
            end
            MEM_SH: begin
                store_data = {2{rt_value[15:0]}};
                lane_strb  = addr[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                lane_strb = 4'b1111;
            end
            default: begin
                lane_strb = '0;
            end
        endcase
    end

    // a clean access that still needs the bus
    assign req_needed = valid && has_access && !early_ex && !adel && !ades;
    assign accept     = data_req.en && data_addr_ok;

    always_comb begin
        data_req.en    = req_needed && (state == req_idle);
        data_req.wr    = store_op;
        data_req.size  = SIZE_WORD;
        data_req.wstrb = (req_needed && store_op) ? lane_strb : '0;
        data_req.addr  = addr;
        data_req.wdata = store_data;
    end

    // leaving wins over a same-cycle accept
    always_comb begin
        state_next = state;
        if (leave) begin
            state_next = req_idle;
        end else if (accept) begin
            state_next = req_sent;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= req_idle;
        end else begin
            state <= state_next;
        end
    end

    // nothing to wait for, or the address was taken
    assign mem_ready = !has_access
                    || early_ex
                    || adel
                    || ades
                    || accept
                    || (state == req_sent);

endmodule

// ==== design/exe_stage.sv ====
module exe_stage
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      ds_to_es_valid,
    input  ds_to_es_t ds_to_es,
    output logic      es_allowin,
    input  logic      ms_allowin,
    output logic      es_to_ms_valid,
    output es_to_ms_t es_to_ms,
    output data_req_t data_req,
    input  logic      data_addr_ok,
    output es_fwd_t   fwd
);

    logic      es_valid;
    ds_to_es_t es_r;
    logic      ready_go;
    logic      leave;
    word_t     alu_result;
    logic      overflow;
    logic      early_ex;
    logic      adel;
    logic      ades;
    logic      mem_ready;
    logic      load_op;
    logic      addr_err;
    ex_code_t  ex_code;

    // flow control
    assign ready_go       = mem_ready;
    assign es_allowin     = !es_valid || (ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && ready_go;
    assign leave          = es_to_ms_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin) begin
            es_r <= ds_to_es;
        end
    end

    exe_alu exe_alu_i (
        .instr    (es_r),
        .result   (alu_result),
        .overflow (overflow)
    );

    // exceptions known before the address check
    assign early_ex = (es_r.ex_code != EX_NONE) || overflow;

    exe_mem_access exe_mem_access_i (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .valid        (es_valid),
        .leave        (leave),
        .mem_op       (es_r.mem_op),
        .early_ex     (early_ex),
        .addr         (alu_result),
        .rt_value     (es_r.rt_value),
        .data_addr_ok (data_addr_ok),
        .data_req     (data_req),
        .adel         (adel),
        .ades         (ades),
        .mem_ready    (mem_ready)
    );

    // decode code first, then overflow, then alignment
    always_comb begin
        if (es_r.ex_code != EX_NONE) begin
            ex_code = es_r.ex_code;
        end else if (overflow) begin
            ex_code = EX_OV;
        end else if (adel) begin
            ex_code = EX_ADEL;
        end else if (ades) begin
            ex_code = EX_ADES;
        end else begin
            ex_code = EX_NONE;
        end
    end

    assign addr_err = !early_ex && (adel || ades);
    assign load_op  = is_load_op(es_r.mem_op);

    always_comb begin
        es_to_ms.ex_code      = ex_code;
        es_to_ms.bad_vaddr    = addr_err ? alu_result : '0;
        es_to_ms.res_from_mem = load_op;
        es_to_ms.gr_we        = es_r.gr_we;
        es_to_ms.dest         = es_r.dest;
        es_to_ms.result       = alu_result;
        es_to_ms.pc           = es_r.pc;
    end

    // hazard info for decode, zero when empty
    always_comb begin
        fwd.dest    = es_valid ? es_r.dest : '0;
        fwd.load_op = es_valid && load_op;
        fwd.data    = es_valid ? alu_result : '0;
    end

endmodule

// ==== tests/exe_checker.sv ====
module exe_checker
    import exe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      ds_to_es_valid,
    input  logic      es_allowin,
    input  logic      ms_allowin,
    input  logic      es_to_ms_valid,
    input  es_to_ms_t es_to_ms,
    input  data_req_t data_req,
    input  logic      data_addr_ok,
    input  es_fwd_t   fwd,
    input  es_to_ms_t exp_out,
    input  data_req_t exp_req,
    output int        pending,
    output int        transfers,
    output int        checks,
    output int        errors
);
    timeunit 1ns;
    timeprecision 1ps;

    // one entry per instruction held in the stage
    es_to_ms_t out_q[$];
    data_req_t req_q[$];
    logic      req_taken;
    logic      held;
    es_to_ms_t held_out;
    logic      mem_wait;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic complain(input string what);
        errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            out_q.delete();
            req_q.delete();
            req_taken = 1'b0;
            held = 1'b0;
        end else begin
            if (out_q.size() == 0) begin
                mem_wait = 1'b0;
                compare("es_to_ms_valid", 32'(es_to_ms_valid), 32'd0);
                compare("data_req.en", 32'(data_req.en), 32'd0);
                compare("data_req.wstrb", 32'(data_req.wstrb), 32'd0);
                compare("es_allowin", 32'(es_allowin), 32'd1);
                compare("fwd.dest", 32'(fwd.dest), 32'd0);
                compare("fwd.load_op", 32'(fwd.load_op), 32'd0);
                compare("fwd.data", fwd.data, 32'd0);
            end else begin
                // a clean access holds the stage until its address is taken
                mem_wait = req_q[0].en && !req_taken;
                compare("data_req.en", 32'(data_req.en), 32'(mem_wait));
                compare("es_to_ms_valid", 32'(es_to_ms_valid), 32'(!mem_wait || data_addr_ok));
                compare("es_allowin", 32'(es_allowin),
                        32'((!mem_wait || data_addr_ok) && ms_allowin));
                compare("fwd.dest", 32'(fwd.dest), 32'(out_q[0].dest));
                compare("fwd.load_op", 32'(fwd.load_op), 32'(out_q[0].res_from_mem));
                compare("fwd.data", fwd.data, out_q[0].result);
            end
            if (flush) begin
                out_q.delete();
                req_q.delete();
                req_taken = 1'b0;
                held = 1'b0;
            end else begin
                if (held && es_to_ms !== held_out) begin
                    errors++;
                    $display("Error at %0t ns: es_to_ms = %h, expected %h while held",
                             $time, es_to_ms, held_out);
                end
                if (data_req.en && data_addr_ok && mem_wait) begin
                    compare("data_req.wr", 32'(data_req.wr), 32'(req_q[0].wr));
                    compare("data_req.size", 32'(data_req.size), 32'(req_q[0].size));
                    compare("data_req.addr", data_req.addr, req_q[0].addr);
                    compare("data_req.wstrb", 32'(data_req.wstrb), 32'(req_q[0].wstrb));
                    if (req_q[0].wr) begin
                        compare("data_req.wdata", data_req.wdata, req_q[0].wdata);
                    end
                    req_taken = 1'b1;
                end
                if (es_to_ms_valid && ms_allowin) begin
                    if (out_q.size() == 0) begin
                        complain("transfer to the memory stage with no instruction expected");
                    end else begin
                        compare("es_to_ms.ex_code", 32'(es_to_ms.ex_code), 32'(out_q[0].ex_code));
                        compare("es_to_ms.bad_vaddr", es_to_ms.bad_vaddr, out_q[0].bad_vaddr);
                        compare("es_to_ms.res_from_mem", 32'(es_to_ms.res_from_mem),
                                32'(out_q[0].res_from_mem));
                        compare("es_to_ms.gr_we", 32'(es_to_ms.gr_we), 32'(out_q[0].gr_we));
                        compare("es_to_ms.dest", 32'(es_to_ms.dest), 32'(out_q[0].dest));
                        compare("es_to_ms.result", es_to_ms.result, out_q[0].result);
                        compare("es_to_ms.pc", es_to_ms.pc, out_q[0].pc);
                        if (req_q[0].en && !req_taken) begin
                            complain("memory instruction left before its request was accepted");
                        end
                        void'(out_q.pop_front());
                        void'(req_q.pop_front());
                        req_taken = 1'b0;
                        transfers++;
                    end
                end
                held = es_to_ms_valid && !ms_allowin;
                held_out = es_to_ms;
                if (ds_to_es_valid && es_allowin) begin
                    out_q.push_back(exp_out);
                    req_q.push_back(exp_req);
                end
            end
            pending = out_q.size();
        end
    end

endmodule

// ==== tests/exe_tb.sv ====
module exe_tb
    import exe_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic      clk;
    logic      reset;
    logic      flush;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es;
    logic      es_allowin;
    logic      ms_allowin;
    logic      es_to_ms_valid;
    es_to_ms_t es_to_ms;
    data_req_t data_req;
    logic      data_addr_ok;
    es_fwd_t   fwd;
    es_to_ms_t exp_out;
    data_req_t exp_req;
    int        pending;
    int        transfers;
    int        checks;
    int        errors;

    always #50 clk = ~clk;

    exe_stage exe_stage_i (
        .clk(clk), .reset(reset), .flush(flush), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es(ds_to_es), .es_allowin(es_allowin), .ms_allowin(ms_allowin),
        .es_to_ms_valid(es_to_ms_valid), .es_to_ms(es_to_ms), .data_req(data_req),
        .data_addr_ok(data_addr_ok), .fwd(fwd)
    );

    exe_checker checker_i (
        .clk(clk), .reset(reset), .flush(flush), .ds_to_es_valid(ds_to_es_valid),
        .es_allowin(es_allowin), .ms_allowin(ms_allowin), .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms(es_to_ms), .data_req(data_req), .data_addr_ok(data_addr_ok), .fwd(fwd),
        .exp_out(exp_out), .exp_req(exp_req), .pending(pending), .transfers(transfers),
        .checks(checks), .errors(errors)
    );

    // reference model of one instruction in the stage
    function automatic void model(input ds_to_es_t d, output es_to_ms_t o, output data_req_t r);
        word_t  a;
        word_t  b;
        word_t  res;
        longint wide;
        logic   ovf;
        logic   ld;
        logic   st;
        logic   bad;
        a = d.src1_is_sa ? {27'b0, d.imm[10:6]} : (d.src1_is_pc ? d.pc : d.rs_value);
        if (d.src2_is_uimm) b = {16'b0, d.imm};
        else if (d.src2_is_imm) b = {{16{d.imm[15]}}, d.imm};
        else if (d.src2_is_8) b = 32'd8;
        else b = d.rt_value;
        case (1'b1)
            d.alu_op[ALU_ADD]:  res = a + b;
            d.alu_op[ALU_SUB]:  res = a - b;
            d.alu_op[ALU_SLT]:  res = {31'b0, $signed(a) < $signed(b)};
            d.alu_op[ALU_SLTU]: res = {31'b0, a < b};
            d.alu_op[ALU_AND]:  res = a & b;
            d.alu_op[ALU_NOR]:  res = ~(a | b);
            d.alu_op[ALU_OR]:   res = a | b;
            d.alu_op[ALU_XOR]:  res = a ^ b;
            d.alu_op[ALU_SLL]:  res = b << a[4:0];
            d.alu_op[ALU_SRL]:  res = b >> a[4:0];
            d.alu_op[ALU_SRA]:  res = word_t'($signed(b) >>> a[4:0]);
            d.alu_op[ALU_LUI]:  res = {b[15:0], 16'b0};
            default:            res = '0;
        endcase
        // exact sum in 64 bits, out of 32-bit signed range means overflow
        if (d.ovf == OVF_SUB) wide = longint'($signed(a)) - longint'($signed(b));
        else wide = longint'($signed(a)) + longint'($signed(b));
        ovf = (d.ovf != OVF_NONE) && (wide > 64'sd2147483647 || wide < -64'sd2147483648);
        ld = d.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        st = d.mem_op inside {MEM_SB, MEM_SH, MEM_SW};
        bad = ((d.mem_op == MEM_LW || d.mem_op == MEM_SW) && res[1:0] != 2'b00)
            || ((d.mem_op inside {MEM_LH, MEM_LHU, MEM_SH}) && res[0]);
        if (d.ex_code != EX_NONE) o.ex_code = d.ex_code;
        else if (ovf) o.ex_code = EX_OV;
        else if (bad && ld) o.ex_code = EX_ADEL;
        else if (bad && st) o.ex_code = EX_ADES;
        else o.ex_code = EX_NONE;
        o.bad_vaddr = (o.ex_code == EX_ADEL || o.ex_code == EX_ADES) ? res : '0;
        o.res_from_mem = ld;
        o.gr_we = d.gr_we;
        o.dest = d.dest;
        o.result = res;
        o.pc = d.pc;
        r.en = (ld || st) && o.ex_code == EX_NONE;
        r.wr = st;
        r.size = SIZE_WORD;
        r.addr = res;
        case (d.mem_op)
            MEM_SB: begin
                r.wstrb = 4'b0001 << res[1:0];
                r.wdata = {4{d.rt_value[7:0]}};
            end
            MEM_SH: begin
                r.wstrb = res[1] ? 4'b1100 : 4'b0011;
                r.wdata = {2{d.rt_value[15:0]}};
            end
            MEM_SW: begin
                r.wstrb = 4'b1111;
                r.wdata = d.rt_value;
            end
            default: begin
                r.wstrb = 4'b0000;
                r.wdata = '0;
            end
        endcase
    endfunction

    // operands near the signed limits trip overflow often
    function automatic word_t operand();
        case ($urandom_range(3))
            0: return 32'h7fff_fff8;
            1: return 32'h8000_0004;
            default: return $urandom;
        endcase
    endfunction

    function automatic ds_to_es_t random_instr(int mem_pct);
        ds_to_es_t d;
        int        op;
        d = '0;
        d.ex_code = ($urandom_range(15) == 0) ? 5'd10 : EX_NONE;
        d.gr_we = 1'($urandom);
        d.dest = reg_idx_t'($urandom);
        d.imm = imm_t'($urandom);
        d.rs_value = operand();
        d.rt_value = operand();
        d.pc = $urandom & 32'hffff_fffc;
        if ($urandom_range(99) < mem_pct) begin
            d.mem_op = mem_op_t'($urandom_range(8, 1));
            d.alu_op = alu_op_t'(1) << ALU_ADD;
            d.src2_is_imm = 1'b1;
            // half of the addresses forced to a word boundary
            if ($urandom_range(1) == 0) begin
                d.rs_value[1:0] = 2'b00;
                d.imm[1:0] = 2'b00;
            end
        end else begin
            op = $urandom_range(11);
            d.alu_op = alu_op_t'(1) << op;
            d.src1_is_sa = ($urandom_range(3) == 0);
            d.src1_is_pc = ($urandom_range(3) == 0);
            d.src2_is_uimm = ($urandom_range(3) == 0);
            d.src2_is_imm = ($urandom_range(3) == 0);
            d.src2_is_8 = ($urandom_range(3) == 0);
            if (op == ALU_ADD && $urandom_range(1) == 1) d.ovf = OVF_ADD;
            if (op == ALU_SUB && $urandom_range(1) == 1) d.ovf = OVF_SUB;
        end
        return d;
    endfunction

    task automatic run_test(input string name, input int count, input int mem_pct,
                            input int stall_pct, input int flush_pm);
        int issued;
        int cycles;
        int errs_before;
        int xfers_before;
        issued = 0;
        cycles = 0;
        errs_before = errors;
        xfers_before = transfers;
        while (issued < count) begin
            if (cycles == count * 40) begin
                $display("timeout: %s accepted only %0d of %0d instructions", name, issued, count);
                $display("TEST FAILED");
                $finish;
            end
            @(negedge clk);
            ds_to_es_valid = ($urandom_range(99) < 80);
            ds_to_es = random_instr(mem_pct);
            ms_allowin = ($urandom_range(99) >= stall_pct);
            data_addr_ok = ($urandom_range(99) >= stall_pct);
            flush = ($urandom_range(999) < flush_pm);
            model(ds_to_es, exp_out, exp_req);
            @(posedge clk);
            if (ds_to_es_valid && es_allowin && !flush) issued++;
            cycles++;
        end
        @(negedge clk);
        ds_to_es_valid = 1'b0;
        flush = 1'b0;
        ms_allowin = 1'b1;
        data_addr_ok = 1'b1;
        cycles = 0;
        // let the stage drain
        while (pending != 0) begin
            if (cycles == 50) begin
                $display("timeout: %s left an instruction stuck in the stage", name);
                $display("TEST FAILED");
                $finish;
            end
            @(negedge clk);
            cycles++;
        end
        $display("%s: %0d accepted, %0d transfers, %0d errors", name, issued,
                 transfers - xfers_before, errors - errs_before);
    endtask

    initial begin
        void'($urandom(32'h9842_da6a));
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es = '0;
        ms_allowin = 1'b1;
        data_addr_ok = 1'b0;
        model(ds_to_es, exp_out, exp_req);
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_test("alu operations", 400, 0, 10, 0);
        run_test("memory access", 400, 70, 30, 0);
        run_test("back-pressure", 300, 50, 60, 0);
        run_test("flush", 300, 50, 30, 30);
        $display("total: %0d transfers, %0d checks, %0d errors", transfers, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== exe_stage.f ====
design/exe_pkg.sv
design/exe_alu.sv
design/exe_mem_access.sv
design/exe_stage.sv
tests/exe_checker.sv
tests/exe_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module exe_tb -f exe_stage.f -o sim_exe
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_exe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    exit 0
else
    exit 1
fi
